// File: verilog/membus_pkg.sv
package membus_pkg;

	// Byte address into the shared memory, wide enough for the tape region
	typedef logic [24:0] mem_addr_t;

	typedef logic [7:0] mem_data_t;

	// Loader requesters on the I/O slots, in falling priority
	typedef enum logic [1:0] {
		SRC_ERASE   = 2'd0,
		SRC_MEMINIT = 2'd1,
		SRC_DL      = 2'd2,
		SRC_TAPE    = 2'd3
	} req_src_e;

endpackage

// File: verilog/loader_pkg.sv
package loader_pkg;

	// ======================================================================
	// Download file kinds as seen on ioctl_index
	// ======================================================================
	localparam logic [7:0] IDX_PRG     = 8'h04;
	localparam logic [7:0] IDX_CRT     = 8'h05;
	localparam logic [7:0] IDX_CRT_ALT = 8'hC0;
	localparam logic [7:0] IDX_TAP     = 8'h06;

	// Fixed regions in the shared memory
	localparam logic [24:0] CART_BASE = 25'h100000;
	localparam logic [24:0] TAP_BASE  = 25'h200000;

	// CRT layout
	localparam logic [7:0] CRT_CHIP_OFS  = 8'h40;
	localparam int         CRT_HDR_BYTES = 16;

	// One CHIP packet header, received as bytes and read as big-endian fields
	typedef union packed {
		logic [15:0][7:0] bytes;
		struct packed {
			logic [31:0] signature;
			logic [31:0] pkt_len;
			logic [15:0] chip_type;
			logic [15:0] bank_num;
			logic [15:0] load_addr;
			logic [15:0] img_size;
		} fields;
	} crt_chip_hdr_u;

	// ======================================================================
	// BASIC zero page pointers, low byte address of each pair
	// ======================================================================
	localparam logic [7:0] PTR_TXT  = 8'h2B;
	localparam logic [7:0] PTR_VAR  = 8'h2D;
	localparam logic [7:0] PTR_ARY  = 8'h2F;
	localparam logic [7:0] PTR_STR  = 8'h31;
	localparam logic [7:0] PTR_SAVE = 8'hAC;
	localparam logic [7:0] PTR_LEND = 8'hAE;

	// Walk stops here, top of the zero page
	localparam logic [8:0] META_END = 9'h100;

endpackage

// File: verilog/download_parser.sv
`timescale 1ns/1ns

module download_parser
	import membus_pkg::*;
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset_n,
	input  logic        ioctl_download_i,
	input  logic [7:0]  ioctl_index_i,
	input  logic        ioctl_wr_i,
	input  mem_addr_t   ioctl_addr_i,
	input  mem_data_t   ioctl_data_i,
	output logic        ioctl_wait_o,
	output logic        dl_req_o,
	output mem_addr_t   dl_addr_o,
	output mem_data_t   dl_data_o,
	input  logic        dl_gnt_i,
	output logic [15:0] prg_end_o,
	output logic        prg_done_o,
	output mem_addr_t   tape_len_o,
	output logic        tape_loaded_o,
	output logic [15:0] cart_id_o,
	output mem_data_t   cart_exrom_o,
	output mem_data_t   cart_game_o,
	output mem_data_t   bank_type_o,
	output logic [15:0] bank_num_o,
	output logic [15:0] bank_laddr_o,
	output logic [15:0] bank_size_o,
	output logic        bank_wr_o,
	output logic        cart_attached_o
);

	logic          is_prg;
	logic          is_crt;
	logic          is_tap;
	logic          in_chips;
	logic          hdr_byte;
	logic          wr_byte;
	logic          old_download;
	mem_addr_t     nxt_addr;
	mem_addr_t     wr_addr;
	crt_chip_hdr_u chip_hdr;
	logic [3:0]    hdr_cnt;
	logic [31:0]   blk_len;

	assign is_prg = ioctl_index_i == IDX_PRG;
	assign is_crt = (ioctl_index_i == IDX_CRT) || (ioctl_index_i == IDX_CRT_ALT);
	assign is_tap = ioctl_index_i == IDX_TAP;

	// Chip packets: a header starts whenever no data is left in the current one
	assign in_chips = is_crt && (ioctl_addr_i >= {17'd0, CRT_CHIP_OFS});
	assign hdr_byte = in_chips && ((hdr_cnt != 4'd0) || (blk_len == 32'd0));

	assign wr_byte = (is_prg && (ioctl_addr_i > 25'd1)) || (in_chips && !hdr_byte) || is_tap;
	assign wr_addr = (is_tap && (ioctl_addr_i == 25'd0)) ? TAP_BASE : nxt_addr;

	assign ioctl_wait_o = dl_req_o;

	assign bank_type_o  = chip_hdr.fields.chip_type[7:0];
	assign bank_num_o   = chip_hdr.fields.bank_num;
	assign bank_laddr_o = chip_hdr.fields.load_addr;
	assign bank_size_o  = chip_hdr.fields.img_size;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_download    <= 1'b0;
			dl_req_o        <= 1'b0;
			hdr_cnt         <= 4'd0;
			blk_len         <= 32'd0;
			bank_wr_o       <= 1'b0;
			prg_done_o      <= 1'b0;
			tape_loaded_o   <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			old_download <= ioctl_download_i;
			bank_wr_o    <= 1'b0;
			prg_done_o   <= 1'b0;

			if (dl_gnt_i)
				dl_req_o <= 1'b0;
			if (ioctl_wr_i && wr_byte)
				dl_req_o <= 1'b1;

			if (ioctl_wr_i && is_crt) begin
				if (ioctl_addr_i == 25'd0) begin
					hdr_cnt <= 4'd0;
					blk_len <= 32'd0;
				end else if (hdr_byte) begin
					hdr_cnt <= hdr_cnt + 1'b1;
					if (hdr_cnt == 4'(CRT_HDR_BYTES - 1)) begin
						blk_len   <= chip_hdr.fields.pkt_len - 32'(CRT_HDR_BYTES);
						bank_wr_o <= 1'b1;
					end
				end else if (in_chips) begin
					blk_len <= blk_len - 1'b1;
				end
			end

			// Download start and end
			if (!old_download && ioctl_download_i) begin
				if (is_crt)
					cart_attached_o <= 1'b0;
				if (is_tap)
					tape_loaded_o <= 1'b0;
			end
			if (old_download && !ioctl_download_i) begin
				prg_done_o <= is_prg;
				if (is_crt)
					cart_attached_o <= 1'b1;
				if (is_tap)
					tape_loaded_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && wr_byte) begin
			dl_addr_o <= wr_addr;
			dl_data_o <= ioctl_data_i;
			nxt_addr  <= wr_addr + 1'b1;
		end

		// PRG header is the load address, low byte first
		if (ioctl_wr_i && is_prg) begin
			if (ioctl_addr_i == 25'd0) begin
				nxt_addr  <= {9'd0, nxt_addr[15:8], ioctl_data_i};
				prg_end_o <= {prg_end_o[15:8], ioctl_data_i};
			end else if (ioctl_addr_i == 25'd1) begin
				nxt_addr[15:8]  <= ioctl_data_i;
				prg_end_o[15:8] <= ioctl_data_i;
			end else begin
				prg_end_o <= prg_end_o + 1'b1;
			end
		end

		if (ioctl_wr_i && is_crt) begin
			case (ioctl_addr_i)
				25'h00: nxt_addr <= CART_BASE;
				25'h16: cart_id_o[15:8] <= ioctl_data_i;
				25'h17: cart_id_o[7:0] <= ioctl_data_i;
				25'h18: cart_exrom_o <= ioctl_data_i;
				25'h19: cart_game_o <= ioctl_data_i;
				default: ;
			endcase
			if (hdr_byte) begin
				chip_hdr.bytes[4'd15 - hdr_cnt] <= ioctl_data_i;
				// New packet data starts on the next 8 KB page
				if ((hdr_cnt == 4'd0) && (nxt_addr[12:0] != 13'd0))
					nxt_addr <= {nxt_addr[24:13] + 1'b1, 13'd0};
			end
		end

		if (ioctl_wr_i && is_tap)
			tape_len_o <= ioctl_addr_i + 1'b1;
	end

	// Source holds off while a byte is still waiting for its slot
	a_no_wr_while_wait: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!(ioctl_wr_i && ioctl_wait_o));

endmodule

// File: verilog/basic_ptr_init.sv
`timescale 1ns/1ns

module basic_ptr_init
	import membus_pkg::*;
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset_n,
	input  logic        prg_done_i,
	input  logic [15:0] prg_end_i,
	output logic        mi_req_o,
	output mem_addr_t   mi_addr_o,
	output mem_data_t   mi_data_o,
	input  logic        mi_gnt_i,
	output logic        inj_done_o
);

	logic       busy;
	logic [8:0] walk;
	logic       ptr_hit;

	assign mi_addr_o = mem_addr_t'(walk);

	// Pointer values as BASIC LOAD would leave them
	always_comb begin
		ptr_hit   = 1'b1;
		mi_data_o = 8'h00;
		case (walk[7:0])
			PTR_TXT:                   mi_data_o = 8'h01;
			PTR_TXT + 8'd1:            mi_data_o = 8'h08;
			PTR_SAVE, PTR_SAVE + 8'd1: mi_data_o = 8'h00;
			PTR_VAR, PTR_ARY, PTR_STR, PTR_LEND:
				mi_data_o = prg_end_i[7:0];
			PTR_VAR + 8'd1, PTR_ARY + 8'd1, PTR_STR + 8'd1, PTR_LEND + 8'd1:
				mi_data_o = prg_end_i[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			busy       <= 1'b0;
			walk       <= 9'd0;
			mi_req_o   <= 1'b0;
			inj_done_o <= 1'b0;
		end else begin
			inj_done_o <= 1'b0;
			if (prg_done_i && !busy) begin
				busy <= 1'b1;
				walk <= 9'd0;
			end else if (busy) begin
				if (mi_req_o) begin
					if (mi_gnt_i) begin
						mi_req_o <= 1'b0;
						walk     <= walk + 1'b1;
					end
				end else if (walk == META_END) begin
					busy       <= 1'b0;
					inj_done_o <= 1'b1;
				end else if (ptr_hit) begin
					mi_req_o <= 1'b1;
				end else begin
					// Other zero page bytes are left as they are
					walk <= walk + 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/ram_eraser.sv
`timescale 1ns/1ns

module ram_eraser
	import membus_pkg::*;
#(
	parameter mem_addr_t   ERASE_TOP = 25'h00FFFF,
	parameter int unsigned ERASE_GAP = 32
) (
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      erase_start_i,
	output logic      er_req_o,
	output mem_addr_t er_addr_o,
	output mem_data_t er_data_o,
	input  logic      er_gnt_i,
	output logic      erase_busy_o
);

	localparam int GW = $clog2(ERASE_GAP + 1);

	logic [GW-1:0] gap_cnt;

	// Power-on pattern, bytes alternate every 64 addresses
	assign er_data_o = {8{er_addr_o[6]}};

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			erase_busy_o <= 1'b0;
			er_req_o     <= 1'b0;
			er_addr_o    <= '0;
			gap_cnt      <= '0;
		end else if (erase_start_i && !erase_busy_o) begin
			erase_busy_o <= 1'b1;
			er_addr_o    <= '0;
			gap_cnt      <= GW'(ERASE_GAP - 1);
		end else if (erase_busy_o) begin
			if (er_req_o) begin
				if (er_gnt_i) begin
					er_req_o <= 1'b0;
					gap_cnt  <= GW'(ERASE_GAP - 1);
					if (er_addr_o == ERASE_TOP)
						erase_busy_o <= 1'b0;
					else
						er_addr_o <= er_addr_o + 1'b1;
				end
			end else if (gap_cnt <= GW'(1)) begin
				er_req_o <= 1'b1;
			end else begin
				gap_cnt <= gap_cnt - 1'b1;
			end
		end
	end

	a_addr_rising: assert property (@(posedge clk_sys) disable iff (!reset_n)
		erase_busy_o && $past(erase_busy_o) |-> er_addr_o >= $past(er_addr_o));

endmodule

// File: verilog/tape_reader.sv
`timescale 1ns/1ns

module tape_reader
	import membus_pkg::*;
	import loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      tape_loaded_i,
	input  mem_addr_t tape_len_i,
	input  logic      tape_play_i,
	input  logic      tape_ready_i,
	output logic      tp_req_o,
	output mem_addr_t tp_addr_o,
	input  logic      tp_gnt_i,
	input  mem_data_t rd_data_i,
	input  logic      rd_valid_i,
	output mem_data_t tape_byte_o,
	output logic      tape_valid_o
);

	logic      play;
	logic      pending;
	mem_addr_t pos;

	assign tp_addr_o = TAP_BASE + pos;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			play         <= 1'b0;
			pending      <= 1'b0;
			pos          <= '0;
			tp_req_o     <= 1'b0;
			tape_valid_o <= 1'b0;
		end else begin
			tape_valid_o <= 1'b0;

			if (!tape_loaded_i) begin
				play <= 1'b0;
				pos  <= '0;
			end else if (tape_play_i) begin
				play <= !play;
			end

			// One read in flight at a time, only while the consumer can take it
			if (play && !tp_req_o && !pending && (pos < tape_len_i) && tape_ready_i)
				tp_req_o <= 1'b1;
			if (tp_gnt_i) begin
				tp_req_o <= 1'b0;
				pending  <= 1'b1;
			end

			if (rd_valid_i && pending) begin
				pending      <= 1'b0;
				tape_valid_o <= 1'b1;
				pos          <= pos + 1'b1;
				if (pos + 1'b1 == tape_len_i)
					play <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd_valid_i && pending)
			tape_byte_o <= rd_data_i;
	end

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter
	import membus_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      io_cycle_i,

	input  logic      er_req_i,
	input  mem_addr_t er_addr_i,
	input  mem_data_t er_data_i,
	output logic      er_gnt_o,

	input  logic      mi_req_i,
	input  mem_addr_t mi_addr_i,
	input  mem_data_t mi_data_i,
	output logic      mi_gnt_o,

	input  logic      dl_req_i,
	input  mem_addr_t dl_addr_i,
	input  mem_data_t dl_data_i,
	output logic      dl_gnt_o,

	input  logic      tp_req_i,
	input  mem_addr_t tp_addr_i,
	output logic      tp_gnt_o,

	input  mem_addr_t c64_addr_i,
	input  logic      c64_ce_i,
	input  logic      c64_we_i,
	input  mem_data_t c64_data_i,

	output mem_addr_t mem_addr_o,
	output logic      mem_ce_o,
	output logic      mem_we_o,
	output mem_data_t mem_data_o,
	input  mem_data_t mem_data_i,

	output mem_data_t rd_data_o,
	output logic      rd_valid_o
);

	logic      io_d;
	logic      first_hi_d;
	logic      slot_prep;
	logic      first_hi;
	logic      any_req;
	req_src_e  pick;
	logic      slot_act;
	req_src_e  slot_src;
	logic      slot_we;
	mem_addr_t slot_addr;
	mem_data_t slot_data;

	assign slot_prep = !io_cycle_i && io_d;
	assign first_hi  = io_cycle_i && !io_d;

	assign any_req = er_req_i || mi_req_i || dl_req_i || tp_req_i;

	always_comb begin
		if (er_req_i)
			pick = SRC_ERASE;
		else if (mi_req_i)
			pick = SRC_MEMINIT;
		else if (dl_req_i)
			pick = SRC_DL;
		else
			pick = SRC_TAPE;
	end

	assign er_gnt_o = slot_prep && any_req && (pick == SRC_ERASE);
	assign mi_gnt_o = slot_prep && any_req && (pick == SRC_MEMINIT);
	assign dl_gnt_o = slot_prep && any_req && (pick == SRC_DL);
	assign tp_gnt_o = slot_prep && any_req && (pick == SRC_TAPE);

	// Only the tape reader reads
	assign slot_we = slot_src != SRC_TAPE;

	// ======================================================================
	// Memory port follows the slot command while io_cycle is high
	// and the computer side while it is low
	// ======================================================================
	assign mem_addr_o = io_cycle_i ? slot_addr : c64_addr_i;
	assign mem_ce_o   = io_cycle_i ? (slot_act && first_hi) : c64_ce_i;
	assign mem_we_o   = io_cycle_i ? (slot_act && slot_we) : c64_we_i;
	assign mem_data_o = io_cycle_i ? slot_data : c64_data_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_d       <= 1'b0;
			first_hi_d <= 1'b0;
			slot_act   <= 1'b0;
			slot_src   <= SRC_ERASE;
			rd_valid_o <= 1'b0;
		end else begin
			io_d       <= io_cycle_i;
			first_hi_d <= first_hi;
			rd_valid_o <= 1'b0;
			if (slot_prep) begin
				slot_act <= any_req;
				slot_src <= pick;
			end
			// Read data is settled by the second high cycle
			if (io_cycle_i && first_hi_d && slot_act && !slot_we)
				rd_valid_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (slot_prep) begin
			case (pick)
				SRC_ERASE: begin
					slot_addr <= er_addr_i;
					slot_data <= er_data_i;
				end
				SRC_MEMINIT: begin
					slot_addr <= mi_addr_i;
					slot_data <= mi_data_i;
				end
				SRC_DL: begin
					slot_addr <= dl_addr_i;
					slot_data <= dl_data_i;
				end
				default: begin
					slot_addr <= tp_addr_i;
				end
			endcase
		end
		if (io_cycle_i && first_hi_d)
			rd_data_o <= mem_data_i;
	end

	a_one_grant: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$onehot0({er_gnt_o, mi_gnt_o, dl_gnt_o, tp_gnt_o}));

endmodule

// File: verilog/c64_loader_top.sv
`timescale 1ns/1ns

module c64_loader_top
	import membus_pkg::*;
#(
	parameter mem_addr_t   ERASE_TOP = 25'h00FFFF,
	parameter int unsigned ERASE_GAP = 32
) (
	input  logic        clk_sys,
	input  logic        reset_n,
	input  logic        io_cycle_i,

	// Download port
	input  logic        ioctl_download_i,
	input  logic [7:0]  ioctl_index_i,
	input  logic        ioctl_wr_i,
	input  mem_addr_t   ioctl_addr_i,
	input  mem_data_t   ioctl_data_i,
	output logic        ioctl_wait_o,

	// Cartridge header fields
	output logic [15:0] cart_id_o,
	output mem_data_t   cart_exrom_o,
	output mem_data_t   cart_game_o,
	output mem_data_t   bank_type_o,
	output logic [15:0] bank_num_o,
	output logic [15:0] bank_laddr_o,
	output logic [15:0] bank_size_o,
	output logic        bank_wr_o,
	output logic        cart_attached_o,

	output logic        inj_done_o,
	input  logic        erase_start_i,
	output logic        erase_busy_o,

	// Tape playback
	input  logic        tape_play_i,
	input  logic        tape_ready_i,
	output mem_data_t   tape_byte_o,
	output logic        tape_valid_o,

	// Computer side and memory port
	input  mem_addr_t   c64_addr_i,
	input  logic        c64_ce_i,
	input  logic        c64_we_i,
	input  mem_data_t   c64_data_i,
	output mem_addr_t   mem_addr_o,
	output logic        mem_ce_o,
	output logic        mem_we_o,
	output mem_data_t   mem_data_o,
	input  mem_data_t   mem_data_i
);

	logic        er_req;
	mem_addr_t   er_addr;
	mem_data_t   er_data;
	logic        er_gnt;
	logic        mi_req;
	mem_addr_t   mi_addr;
	mem_data_t   mi_data;
	logic        mi_gnt;
	logic        dl_req;
	mem_addr_t   dl_addr;
	mem_data_t   dl_data;
	logic        dl_gnt;
	logic        tp_req;
	mem_addr_t   tp_addr;
	logic        tp_gnt;
	mem_data_t   rd_data;
	logic        rd_valid;
	logic [15:0] prg_end;
	logic        prg_done;
	mem_addr_t   tape_len;
	logic        tape_loaded;

	download_parser i_parser (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.ioctl_download_i(ioctl_download_i),
		.ioctl_index_i   (ioctl_index_i),
		.ioctl_wr_i      (ioctl_wr_i),
		.ioctl_addr_i    (ioctl_addr_i),
		.ioctl_data_i    (ioctl_data_i),
		.ioctl_wait_o    (ioctl_wait_o),
		.dl_req_o        (dl_req),
		.dl_addr_o       (dl_addr),
		.dl_data_o       (dl_data),
		.dl_gnt_i        (dl_gnt),
		.prg_end_o       (prg_end),
		.prg_done_o      (prg_done),
		.tape_len_o      (tape_len),
		.tape_loaded_o   (tape_loaded),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o)
	);

	basic_ptr_init i_meminit (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.prg_done_i(prg_done),
		.prg_end_i (prg_end),
		.mi_req_o  (mi_req),
		.mi_addr_o (mi_addr),
		.mi_data_o (mi_data),
		.mi_gnt_i  (mi_gnt),
		.inj_done_o(inj_done_o)
	);

	ram_eraser #(
		.ERASE_TOP(ERASE_TOP),
		.ERASE_GAP(ERASE_GAP)
	) i_eraser (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.erase_start_i(erase_start_i),
		.er_req_o     (er_req),
		.er_addr_o    (er_addr),
		.er_data_o    (er_data),
		.er_gnt_i     (er_gnt),
		.erase_busy_o (erase_busy_o)
	);

	tape_reader i_tape (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.tape_loaded_i(tape_loaded),
		.tape_len_i   (tape_len),
		.tape_play_i  (tape_play_i),
		.tape_ready_i (tape_ready_i),
		.tp_req_o     (tp_req),
		.tp_addr_o    (tp_addr),
		.tp_gnt_i     (tp_gnt),
		.rd_data_i    (rd_data),
		.rd_valid_i   (rd_valid),
		.tape_byte_o  (tape_byte_o),
		.tape_valid_o (tape_valid_o)
	);

	mem_arbiter i_arbiter (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.io_cycle_i(io_cycle_i),
		.er_req_i  (er_req),
		.er_addr_i (er_addr),
		.er_data_i (er_data),
		.er_gnt_o  (er_gnt),
		.mi_req_i  (mi_req),
		.mi_addr_i (mi_addr),
		.mi_data_i (mi_data),
		.mi_gnt_o  (mi_gnt),
		.dl_req_i  (dl_req),
		.dl_addr_i (dl_addr),
		.dl_data_i (dl_data),
		.dl_gnt_o  (dl_gnt),
		.tp_req_i  (tp_req),
		.tp_addr_i (tp_addr),
		.tp_gnt_o  (tp_gnt),
		.c64_addr_i(c64_addr_i),
		.c64_ce_i  (c64_ce_i),
		.c64_we_i  (c64_we_i),
		.c64_data_i(c64_data_i),
		.mem_addr_o(mem_addr_o),
		.mem_ce_o  (mem_ce_o),
		.mem_we_o  (mem_we_o),
		.mem_data_o(mem_data_o),
		.mem_data_i(mem_data_i),
		.rd_data_o (rd_data),
		.rd_valid_o(rd_valid)
	);

endmodule

// File: test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ======================================================================
// Expected memory contents and tape stream
// ======================================================================
mem_data_t exp_mem [mem_addr_t];
mem_data_t exp_tape [$];

// Linear congruential step on a 32-bit state
function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// Background of untouched memory is built from every address bit
function automatic mem_data_t fill_byte(input mem_addr_t a);
	return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'h5A;
endfunction

task automatic model_write(input mem_addr_t a, input mem_data_t d);
	exp_mem[a] = d;
endtask

// Power-on pattern of 64 bytes of 00 then 64 bytes of FF
function automatic mem_data_t erase_byte(input mem_addr_t a);
	return a[6] ? 8'hFF : 8'h00;
endfunction

// BASIC pointers after a PRG load ending at end_ptr
task automatic model_basic_ptrs(input logic [15:0] end_ptr);
	model_write(25'h2B, 8'h01);
	model_write(25'h2C, 8'h08);
	model_write(25'hAC, 8'h00);
	model_write(25'hAD, 8'h00);
	model_write(25'h2D, end_ptr[7:0]);
	model_write(25'h2F, end_ptr[7:0]);
	model_write(25'h31, end_ptr[7:0]);
	model_write(25'hAE, end_ptr[7:0]);
	model_write(25'h2E, end_ptr[15:8]);
	model_write(25'h30, end_ptr[15:8]);
	model_write(25'h32, end_ptr[15:8]);
	model_write(25'hAF, end_ptr[15:8]);
endtask

`endif

// File: test/tb_loader.sv
`timescale 1ns/1ns

module tb_loader
	import membus_pkg::*;
	import loader_pkg::*;
;

	logic        clk_sys;
	logic        reset_n;
	logic        io_cycle_i;
	logic        ioctl_download_i;
	logic [7:0]  ioctl_index_i;
	logic        ioctl_wr_i;
	mem_addr_t   ioctl_addr_i;
	mem_data_t   ioctl_data_i;
	logic        ioctl_wait_o;
	logic [15:0] cart_id_o;
	mem_data_t   cart_exrom_o;
	mem_data_t   cart_game_o;
	mem_data_t   bank_type_o;
	logic [15:0] bank_num_o;
	logic [15:0] bank_laddr_o;
	logic [15:0] bank_size_o;
	logic        bank_wr_o;
	logic        cart_attached_o;
	logic        inj_done_o;
	logic        erase_start_i;
	logic        erase_busy_o;
	logic        tape_play_i;
	logic        tape_ready_i;
	mem_data_t   tape_byte_o;
	logic        tape_valid_o;
	mem_addr_t   c64_addr_i;
	logic        c64_ce_i;
	logic        c64_we_i;
	mem_data_t   c64_data_i;
	mem_addr_t   mem_addr_o;
	logic        mem_ce_o;
	logic        mem_we_o;
	mem_data_t   mem_data_o;
	mem_data_t   mem_data_i;

	logic [31:0]   rng_state = 32'd36;
	logic          io_run;
	int            io_cnt;
	logic          ready_rand;
	mem_data_t     sim_mem [mem_addr_t];
	mem_data_t     got_tape [$];
	crt_chip_hdr_u exp_hdr [$];
	int            bank_seen;

	`include "tb_model.svh"

	c64_loader_top #(
		.ERASE_TOP(25'h0000FF),
		.ERASE_GAP(4)
	) i_dut (.*);

	function automatic int unsigned rnd(input int unsigned n);
		rng_state = lcg_step(rng_state);
		return (rng_state >> 12) % n;
	endfunction

	function automatic mem_data_t peek(input mem_addr_t a);
		if (sim_mem.exists(a))
			return sim_mem[a];
		return fill_byte(a);
	endfunction

	// ======================================================================
	// Failure reporting and compare tasks
	// ======================================================================
	task automatic stop_on_error(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string what, input mem_data_t got, input mem_data_t exp);
		if (got !== exp)
			stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_word(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_bank(input crt_chip_hdr_u exp);
		check_byte("bank type", bank_type_o, exp.fields.chip_type[7:0]);
		check_word("bank number", bank_num_o, exp.fields.bank_num);
		check_word("bank load address", bank_laddr_o, exp.fields.load_addr);
		check_word("bank size", bank_size_o, exp.fields.img_size);
	endtask

	task automatic check_memory();
		foreach (exp_mem[a])
			check_byte($sformatf("memory at %h", a), peek(a), exp_mem[a]);
	endtask

	// Inputs change a little after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic wait_io(input logic level);
		int t;
		t = 0;
		while (io_cycle_i !== level) begin
			tick();
			t++;
			if (t > 100)
				stop_on_timeout("an I/O slot phase");
		end
	endtask

	// One full slot lets a granted write reach memory
	task automatic wait_slot();
		wait_io(1'b1);
		wait_io(1'b0);
	endtask

	// ======================================================================
	// Clock, I/O slots, memory model and monitors
	// ======================================================================
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		io_cycle_i = 1'b0;
		io_cnt = 2;
		forever begin
			tick();
			if (io_cnt > 0) begin
				io_cnt--;
			end else if (io_cycle_i) begin
				io_cycle_i = 1'b0;
				io_cnt = 1 + rnd(4);
			end else if (io_run) begin
				io_cycle_i = 1'b1;
				io_cnt = 1 + rnd(4);
			end
		end
	end

	always @(posedge clk_sys) begin
		if (mem_ce_o) begin
			if (mem_we_o)
				sim_mem[mem_addr_o] = mem_data_o;
			else
				mem_data_i <= peek(mem_addr_o);
		end
	end

	always @(posedge clk_sys) begin
		if (reset_n && tape_valid_o)
			got_tape.push_back(tape_byte_o);
		if (reset_n && bank_wr_o) begin
			if (bank_seen >= exp_hdr.size())
				stop_on_error("unexpected bank_wr_o pulse");
			check_bank(exp_hdr[bank_seen]);
			bank_seen++;
		end
	end

	always @(posedge clk_sys) begin
		#2;
		if (ready_rand)
			tape_ready_i = (rnd(3) != 0);
	end

	// ======================================================================
	// Download helpers
	// ======================================================================
	task automatic send_byte(input mem_addr_t a, input mem_data_t d);
		int t;
		t = 0;
		while (ioctl_wait_o) begin
			tick();
			t++;
			if (t > 200)
				stop_on_timeout("ioctl_wait_o to fall");
		end
		ioctl_addr_i = a;
		ioctl_data_i = d;
		ioctl_wr_i = 1'b1;
		tick();
		ioctl_wr_i = 1'b0;
		tick();
	endtask

	task automatic start_download(input logic [7:0] idx);
		ioctl_index_i = idx;
		ioctl_download_i = 1'b1;
		tick();
	endtask

	task automatic end_download();
		int t;
		t = 0;
		while (ioctl_wait_o) begin
			tick();
			t++;
			if (t > 200)
				stop_on_timeout("the last download write");
		end
		ioctl_download_i = 1'b0;
		tick();
		wait_slot();
	endtask

	// ======================================================================
	// Behaviors
	// ======================================================================
	task automatic run_erase();
		int t;
		erase_start_i = 1'b1;
		tick();
		erase_start_i = 1'b0;
		t = 0;
		while (erase_busy_o) begin
			tick();
			t++;
			if (t > 20000)
				stop_on_timeout("erase_busy_o to fall");
		end
		wait_slot();
		for (int a = 0; a <= 'hFF; a++)
			model_write(mem_addr_t'(a), erase_byte(mem_addr_t'(a)));
		check_memory();
	endtask

	task automatic run_prg();
		logic [15:0] load;
		int          n;
		int          t;
		mem_data_t   d;
		load = 16'h0800 + 16'(rnd(16'h1000));
		n = 10 + rnd(51);
		start_download(IDX_PRG);
		send_byte(25'd0, load[7:0]);
		send_byte(25'd1, load[15:8]);
		for (int i = 0; i < n; i++) begin
			d = mem_data_t'(rnd(256));
			send_byte(mem_addr_t'(i + 2), d);
			model_write(mem_addr_t'(load + 16'(i)), d);
		end
		end_download();
		t = 0;
		while (!inj_done_o) begin
			tick();
			t++;
			if (t > 5000)
				stop_on_timeout("inj_done_o");
		end
		wait_slot();
		model_basic_ptrs(load + 16'(n));
		check_memory();
	endtask

	task automatic run_crt();
		mem_data_t     hdr [64];
		crt_chip_hdr_u h;
		mem_addr_t     pos;
		int            dlen;
		int            t;
		mem_data_t     d;
		for (int i = 0; i < 64; i++)
			hdr[i] = mem_data_t'(rnd(256));
		start_download(IDX_CRT);
		for (int i = 0; i < 64; i++)
			send_byte(mem_addr_t'(i), hdr[i]);
		pos = 25'h40;
		for (int p = 0; p < 2; p++) begin
			dlen = 8 + rnd(33);
			h.fields.signature = 32'h43484950;
			h.fields.pkt_len   = 32'(16 + dlen);
			h.fields.chip_type = 16'(rnd(65536));
			h.fields.bank_num  = 16'(p);
			h.fields.load_addr = p ? 16'hA000 : 16'h8000;
			h.fields.img_size  = 16'h2000;
			exp_hdr.push_back(h);
			// Header bytes go out most significant first
			for (int i = 0; i < 16; i++) begin
				send_byte(pos, h.bytes[15 - i]);
				pos++;
			end
			for (int i = 0; i < dlen; i++) begin
				d = mem_data_t'(rnd(256));
				send_byte(pos, d);
				pos++;
				model_write(CART_BASE + mem_addr_t'(p * 'h2000 + i), d);
			end
		end
		end_download();
		t = 0;
		while (!cart_attached_o) begin
			tick();
			t++;
			if (t > 100)
				stop_on_timeout("cart_attached_o");
		end
		check_word("cartridge ID", cart_id_o, {hdr[16'h16], hdr[16'h17]});
		check_byte("EXROM", cart_exrom_o, hdr[16'h18]);
		check_byte("GAME", cart_game_o, hdr[16'h19]);
		if (bank_seen != 2)
			stop_on_error($sformatf("saw %0d bank_wr_o pulses, expected 2", bank_seen));
		check_memory();
	endtask

	task automatic run_tap();
		int        n;
		int        t;
		mem_data_t d;
		n = 20 + rnd(41);
		start_download(IDX_TAP);
		for (int i = 0; i < n; i++) begin
			d = mem_data_t'(rnd(256));
			send_byte(mem_addr_t'(i), d);
			model_write(TAP_BASE + mem_addr_t'(i), d);
			exp_tape.push_back(d);
		end
		end_download();
		check_memory();
		tape_play_i = 1'b1;
		ready_rand = 1'b1;
		tick();
		tape_play_i = 1'b0;
		t = 0;
		while (got_tape.size() < n) begin
			tick();
			t++;
			if (t > 20000)
				stop_on_timeout("the tape byte stream");
		end
		ready_rand = 1'b0;
		tape_ready_i = 1'b1;
		for (int i = 0; i < n; i++)
			check_byte($sformatf("tape byte %0d", i), got_tape[i], exp_tape[i]);
	endtask

	task automatic run_c64();
		mem_addr_t addrs [8];
		mem_data_t d;
		io_run = 1'b0;
		wait_io(1'b0);
		for (int k = 0; k < 8; k++) begin
			addrs[k] = 25'h300000 + mem_addr_t'(rnd(65536));
			d = mem_data_t'(rnd(256));
			c64_addr_i = addrs[k];
			c64_data_i = d;
			c64_ce_i = 1'b1;
			c64_we_i = 1'b1;
			tick();
			c64_ce_i = 1'b0;
			c64_we_i = 1'b0;
			model_write(addrs[k], d);
		end
		check_memory();
		for (int k = 0; k < 8; k++) begin
			c64_addr_i = addrs[k];
			c64_ce_i = 1'b1;
			tick();
			c64_ce_i = 1'b0;
			check_byte("computer read", mem_data_i, exp_mem[addrs[k]]);
		end
		io_run = 1'b1;
	endtask

	initial begin
		reset_n = 1'b0;
		io_run = 1'b1;
		ready_rand = 1'b0;
		bank_seen = 0;
		ioctl_download_i = 1'b0;
		ioctl_index_i = 8'h00;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_data_i = '0;
		erase_start_i = 1'b0;
		tape_play_i = 1'b0;
		tape_ready_i = 1'b1;
		c64_addr_i = '0;
		c64_ce_i = 1'b0;
		c64_we_i = 1'b0;
		c64_data_i = '0;
		mem_data_i = '0;
		repeat (5) @(posedge clk_sys);
		#2;
		reset_n = 1'b1;
		tick();
		run_prg();
		run_erase();
		run_crt();
		run_tap();
		run_c64();
		$display("test passed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+test
verilog/membus_pkg.sv
verilog/loader_pkg.sv
verilog/download_parser.sv
verilog/basic_ptr_init.sv
verilog/ram_eraser.sv
verilog/tape_reader.sv
verilog/mem_arbiter.sv
verilog/c64_loader_top.sv
test/tb_loader.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_loader
	./obj_dir/Vtb_loader | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
